// File: src/branch_pkg.sv
// Branch resolution package with widths, opcodes, compare functions and link registers
package branch_pkg;

    ////////////////////
    // Widths and sizes

    // Data and address width
    localparam int XLEN = 32;

    // Return address stack
    localparam int RAS_DEPTH = 4;
    localparam int RAS_PTR_W = 2;

    // Statistics counter width
    localparam int STAT_W = 16;

    ////////////////////
    // Encodings

    // Major opcodes, instruction bits 6:2
    typedef enum logic [4:0] {
        OPC_BRANCH = 5'b11000,
        OPC_JALR   = 5'b11001,
        OPC_JAL    = 5'b11011
    } opcode_e;

    // Kind of control transfer
    typedef enum logic [1:0] {
        KIND_BRANCH,
        KIND_JAL,
        KIND_JALR,
        KIND_NONE
    } branch_kind_e;

    // Compare function, straight from funct3
    typedef enum logic [2:0] {
        CMP_EQ  = 3'd0,
        CMP_NE  = 3'd1,
        CMP_LT  = 3'd4,
        CMP_GE  = 3'd5,
        CMP_LTU = 3'd6,
        CMP_GEU = 3'd7
    } cmp_fn_e;

    // Link registers used by the call/return hints
    localparam logic [4:0] LINK_RA = 5'd1;
    localparam logic [4:0] LINK_T0 = 5'd5;

    // True for x1 or x5
    function automatic logic is_link(input logic [4:0] reg_idx);
        return (reg_idx == LINK_RA) || (reg_idx == LINK_T0);
    endfunction

endpackage

// File: src/branch_comparator.sv
// Branch comparator giving equality or signed/unsigned less-than of two words
`timescale 1ns/1ns

module branch_comparator (
    input  logic [branch_pkg::XLEN-1:0] a,
    input  logic [branch_pkg::XLEN-1:0] b,
    input  logic                        use_signed,
    input  logic                        less_than,
    output logic                        result
);

    // One extra bit so a single subtract covers both signednesses
    logic [branch_pkg::XLEN:0] a_ext;
    logic [branch_pkg::XLEN:0] b_ext;
    logic [branch_pkg::XLEN:0] diff;
    logic                      lt;
    logic                      eq;

    // Sign extend for signed, zero extend for unsigned
    assign a_ext = {use_signed & a[branch_pkg::XLEN-1], a};
    assign b_ext = {use_signed & b[branch_pkg::XLEN-1], b};
    assign diff  = a_ext - b_ext;

    // Borrow out of the top bit means a < b
    assign lt = diff[branch_pkg::XLEN];
    assign eq = (a == b);

    assign result = less_than ? lt : eq;

endmodule

// File: src/branch_unit.sv
// Branch unit that decodes, compares and holds a branch, then resolves target and flush
`timescale 1ns/1ns

module branch_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        new_request,
    input  logic [31:0]                 instruction,
    input  logic [branch_pkg::XLEN-1:0] rs1,
    input  logic [branch_pkg::XLEN-1:0] rs2,
    input  logic [branch_pkg::XLEN-1:0] dec_pc,
    input  logic                        dec_pc_valid,
    output logic                        branch_ex,
    output logic                        branch_taken,
    output logic                        flush,
    output logic [branch_pkg::XLEN-1:0] jump_pc,
    output logic [branch_pkg::XLEN-1:0] njump_pc,
    output logic                        is_return_ex,
    output logic                        ras_push,
    output logic                        ras_pop
);

    // Issue-cycle decode
    branch_pkg::branch_kind_e    kind;
    branch_pkg::cmp_fn_e         cmp_fn;
    logic [4:0]                  rd_idx;
    logic [4:0]                  rs1_idx;
    logic [branch_pkg::XLEN-1:0] imm_b;
    logic [branch_pkg::XLEN-1:0] imm_j;
    logic [branch_pkg::XLEN-1:0] imm_i;
    logic [branch_pkg::XLEN-1:0] offset;
    logic [branch_pkg::XLEN-1:0] base;
    logic [branch_pkg::XLEN-1:0] target;
    logic                        cmp_signed;
    logic                        cmp_less_than;
    logic                        cmp_result;
    logic                        is_call;
    logic                        is_return;

    // Held state
    logic                        pending;
    logic                        capture;
    logic                        completing;
    branch_pkg::branch_kind_e    kind_ex;
    branch_pkg::cmp_fn_e         fn_ex;
    logic                        result_ex;
    logic                        call_ex;
    logic                        return_ex;
    logic [branch_pkg::XLEN-1:0] next_pc;

    ////////////////////
    // Decode

    always_comb begin
        case (instruction[6:2])
            branch_pkg::OPC_BRANCH: kind = branch_pkg::KIND_BRANCH;
            branch_pkg::OPC_JAL:    kind = branch_pkg::KIND_JAL;
            branch_pkg::OPC_JALR:   kind = branch_pkg::KIND_JALR;
            default:                kind = branch_pkg::KIND_NONE;
        endcase
    end

    assign cmp_fn  = branch_pkg::cmp_fn_e'(instruction[14:12]);
    assign rd_idx  = instruction[11:7];
    assign rs1_idx = instruction[19:15];

    // B, J and I immediates, all sign extended
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};
    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};

    always_comb begin
        case (kind)
            branch_pkg::KIND_JAL:  offset = imm_j;
            branch_pkg::KIND_JALR: offset = imm_i;
            default:               offset = imm_b;
        endcase
    end

    // JALR is register relative, the rest are pc relative
    assign base   = (kind == branch_pkg::KIND_JALR) ? rs1 : dec_pc;
    assign target = base + offset;

    ////////////////////
    // Compare

    assign cmp_signed    = (cmp_fn == branch_pkg::CMP_LT) || (cmp_fn == branch_pkg::CMP_GE);
    assign cmp_less_than = cmp_fn inside {branch_pkg::CMP_LT, branch_pkg::CMP_GE,
                                          branch_pkg::CMP_LTU, branch_pkg::CMP_GEU};

    branch_comparator comparator (
        .a          (rs1),
        .b          (rs2),
        .use_signed (cmp_signed),
        .less_than  (cmp_less_than),
        .result     (cmp_result)
    );

    // Call and return hints
    // Link to link with different registers does pop then push
    assign is_call   = ((kind == branch_pkg::KIND_JAL) || (kind == branch_pkg::KIND_JALR))
                       && branch_pkg::is_link(rd_idx);
    assign is_return = (kind == branch_pkg::KIND_JALR) && branch_pkg::is_link(rs1_idx)
                       && (!branch_pkg::is_link(rd_idx) || (rd_idx != rs1_idx));

    ////////////////////
    // Hold until next pc

    // Set wins over clear, so a back-to-back issue stays pending
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (new_request) begin
            pending <= 1'b1;
        end else if (dec_pc_valid) begin
            pending <= 1'b0;
        end
    end

    assign completing = pending & dec_pc_valid;
    assign capture    = ~pending | completing;

    always_ff @(posedge clk) begin
        if (capture) begin
            kind_ex   <= kind;
            fn_ex     <= cmp_fn;
            result_ex <= cmp_result;
            jump_pc   <= {target[branch_pkg::XLEN-1:1], 1'b0};
            njump_pc  <= dec_pc + branch_pkg::XLEN'(4);
            call_ex   <= is_call;
            return_ex <= is_return;
        end
    end

    ////////////////////
    // Resolve

    // Jumps always taken, NE/GE/GEU invert the raw compare
    always_comb begin
        case (kind_ex)
            branch_pkg::KIND_JAL,
            branch_pkg::KIND_JALR:   branch_taken = 1'b1;
            branch_pkg::KIND_BRANCH: branch_taken = result_ex ^ (fn_ex inside
                {branch_pkg::CMP_NE, branch_pkg::CMP_GE, branch_pkg::CMP_GEU});
            default:                 branch_taken = 1'b0;
        endcase
    end

    assign next_pc = branch_taken ? jump_pc : njump_pc;

    assign branch_ex    = completing;
    // Bit 0 of the arriving pc is ignored
    assign flush        = completing && (dec_pc[branch_pkg::XLEN-1:1] !=
                                         next_pc[branch_pkg::XLEN-1:1]);
    assign is_return_ex = return_ex;
    assign ras_push     = completing & call_ex;
    assign ras_pop      = completing & return_ex;

    ////////////////////
    // Checks

    // One branch in flight at a time
    no_issue_while_pending: assert property (@(posedge clk) disable iff (rst)
        new_request |-> (!pending || completing));

    // Only branches and jumps are issued
    issue_is_branch: assert property (@(posedge clk) disable iff (rst)
        new_request |-> (kind != branch_pkg::KIND_NONE));

endmodule

// File: src/return_stack.sv
// Return address stack as a circular buffer with push, pop and replace
`timescale 1ns/1ns

module return_stack (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  logic                        pop,
    input  logic [branch_pkg::XLEN-1:0] new_addr,
    output logic [branch_pkg::XLEN-1:0] top
);

    logic [branch_pkg::XLEN-1:0]  entries [branch_pkg::RAS_DEPTH];
    // Points at the current top entry
    logic [branch_pkg::RAS_PTR_W-1:0] ptr;
    // Valid entries, 0 to RAS_DEPTH
    logic [branch_pkg::RAS_PTR_W:0]   count;

    // Pointer and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr   <= '0;
            count <= '0;
        end else if (push && pop) begin
            // Replace keeps the pointer, empty becomes one entry
            if (count == '0) begin
                count <= count + 1'b1;
            end
        end else if (push) begin
            // Wraps over the oldest entry when full
            ptr <= ptr + 1'b1;
            if (count < branch_pkg::RAS_DEPTH) begin
                count <= count + 1'b1;
            end
        end else if (pop) begin
            // Pop on empty is ignored
            if (count != '0) begin
                ptr   <= ptr - 1'b1;
                count <= count - 1'b1;
            end
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (push && pop) begin
            entries[ptr] <= new_addr;
        end else if (push) begin
            entries[ptr + 1'b1] <= new_addr;
        end
    end

    assign top = (count == '0) ? '0 : entries[ptr];

    // Occupancy bounded by the depth
    count_in_range: assert property (@(posedge clk) disable iff (rst)
        count <= branch_pkg::RAS_DEPTH);

endmodule

// File: src/branch_stats.sv
// Branch statistics with saturating counters for correct and mispredicted events
`timescale 1ns/1ns

module branch_stats (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          branch_ex,
    input  logic                          is_return,
    input  logic                          flush,
    output logic [branch_pkg::STAT_W-1:0] branches_ok,
    output logic [branch_pkg::STAT_W-1:0] branches_bad,
    output logic [branch_pkg::STAT_W-1:0] returns_ok,
    output logic [branch_pkg::STAT_W-1:0] returns_bad
);

    // Indexed by {is_return, flush}
    logic [branch_pkg::STAT_W-1:0] counts [4];
    logic [1:0]                    sel;

    assign sel = {is_return, flush};

    // Hold at all ones once saturated
    always_ff @(posedge clk) begin
        if (rst) begin
            counts <= '{default: '0};
        end else if (branch_ex && (counts[sel] != '1)) begin
            counts[sel] <= counts[sel] + 1'b1;
        end
    end

    assign branches_ok  = counts[0];
    assign branches_bad = counts[1];
    assign returns_ok   = counts[2];
    assign returns_bad  = counts[3];

endmodule

// File: src/branch_resolve_top.sv
// Branch resolution top connecting branch unit, return stack and statistics
`timescale 1ns/1ns

module branch_resolve_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          new_request,
    input  logic [31:0]                   instruction,
    input  logic [branch_pkg::XLEN-1:0]   rs1,
    input  logic [branch_pkg::XLEN-1:0]   rs2,
    input  logic [branch_pkg::XLEN-1:0]   dec_pc,
    input  logic                          dec_pc_valid,
    output logic                          branch_ex,
    output logic                          branch_taken,
    output logic                          flush,
    output logic [branch_pkg::XLEN-1:0]   jump_pc,
    output logic [branch_pkg::XLEN-1:0]   njump_pc,
    output logic [branch_pkg::XLEN-1:0]   ras_top,
    output logic [branch_pkg::STAT_W-1:0] branches_ok,
    output logic [branch_pkg::STAT_W-1:0] branches_bad,
    output logic [branch_pkg::STAT_W-1:0] returns_ok,
    output logic [branch_pkg::STAT_W-1:0] returns_bad
);

    logic is_return_ex;
    logic ras_push;
    logic ras_pop;

    branch_unit unit (
        .clk, .rst, .new_request, .instruction, .rs1, .rs2, .dec_pc, .dec_pc_valid,
        .branch_ex, .branch_taken, .flush, .jump_pc, .njump_pc,
        .is_return_ex, .ras_push, .ras_pop
    );

    // Return address is the fall-through pc
    return_stack ras (
        .clk, .rst,
        .push     (ras_push),
        .pop      (ras_pop),
        .new_addr (njump_pc),
        .top      (ras_top)
    );

    branch_stats stats (
        .clk, .rst, .branch_ex,
        .is_return (is_return_ex),
        .flush,
        .branches_ok, .branches_bad, .returns_ok, .returns_bad
    );

endmodule

// File: verif/branch_tb.sv
// Branch resolution testbench with random branches, a reference model and assertions
`timescale 1ns/1ns

module branch_tb;

    localparam int NUM_BRANCHES = 300;
    localparam int WAIT_LIMIT   = 16;

    // DUT ports
    logic        clk;
    logic        rst;
    logic        new_request;
    logic        dec_pc_valid;
    logic [31:0] instruction, rs1, rs2, dec_pc;
    logic        branch_ex, branch_taken, flush;
    logic [31:0] jump_pc, njump_pc, ras_top;
    logic [branch_pkg::STAT_W-1:0] branches_ok, branches_bad, returns_ok, returns_bad;

    // Model outputs, updated on the falling edge with the stimulus
    logic        exp_ex = 1'b0;
    logic        exp_flush = 1'b0;
    logic        exp_taken, exp_call, exp_return;
    logic [31:0] exp_jump, exp_njump;
    logic [31:0] exp_top = '0;
    logic [31:0] ras_model [$];
    logic [branch_pkg::STAT_W-1:0] br_ok = '0, br_bad = '0, ret_ok = '0, ret_bad = '0;

    integer      seed;
    logic [31:0] r;
    int          value_errors = 0;
    int          other_errors = 0;
    logic        timed_out = 1'b0;

    branch_resolve_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        value_errors++;
        $display("error at %0t: %s is %h, expected %h", $time, name, got, want);
    endtask

    // Link register half the time
    function automatic logic [4:0] link_or_any(input logic [7:0] v);
        if (v[1]) begin
            return v[0] ? branch_pkg::LINK_T0 : branch_pkg::LINK_RA;
        end
        return v[6:2];
    endfunction

    // 0 branch, 1 JAL, 2 JALR, other fields random
    function automatic logic [31:0] make_word(input int sel, input logic [4:0] rd,
                                              input logic [4:0] rs);
        logic [31:0] w;
        w        = $random(seed);
        w[11:7]  = rd;
        w[19:15] = rs;
        if (sel == 1) begin
            w[6:0] = {branch_pkg::OPC_JAL, 2'b11};
        end else if (sel == 2) begin
            w[6:0]   = {branch_pkg::OPC_JALR, 2'b11};
            w[14:12] = 3'd0;
        end else begin
            w[6:0] = {branch_pkg::OPC_BRANCH, 2'b11};
            // funct3 2 and 3 are no branches, move them to LTU and GEU
            w[14]  = w[14] | w[13];
        end
        return w;
    endfunction

    // Expected result from the RISC-V branch, jump and link hint rules
    task automatic predict(input logic [31:0] w, input logic [31:0] pc,
                           input logic [31:0] a, input logic [31:0] b);
        logic [31:0] imm;
        logic        rd_link;
        logic        rs_link;
        rd_link    = (w[11:7] == branch_pkg::LINK_RA) || (w[11:7] == branch_pkg::LINK_T0);
        rs_link    = (w[19:15] == branch_pkg::LINK_RA) || (w[19:15] == branch_pkg::LINK_T0);
        exp_taken  = 1'b1;
        exp_call   = (w[6:2] != branch_pkg::OPC_BRANCH) && rd_link;
        exp_return = 1'b0;
        exp_njump  = pc + 32'd4;
        case (w[6:2])
            branch_pkg::OPC_JAL: begin
                imm      = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                exp_jump = pc + imm;
            end
            branch_pkg::OPC_JALR: begin
                imm        = {{21{w[31]}}, w[30:20]};
                exp_jump   = a + imm;
                exp_return = rs_link && (!rd_link || (w[11:7] != w[19:15]));
            end
            default: begin
                imm      = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                exp_jump = pc + imm;
                case (w[14:12])
                    branch_pkg::CMP_EQ:  exp_taken = (a == b);
                    branch_pkg::CMP_NE:  exp_taken = (a != b);
                    branch_pkg::CMP_LT:  exp_taken = ($signed(a) < $signed(b));
                    branch_pkg::CMP_GE:  exp_taken = ($signed(a) >= $signed(b));
                    branch_pkg::CMP_LTU: exp_taken = (a < b);
                    default:             exp_taken = (a >= b);
                endcase
            end
        endcase
        exp_jump[0] = 1'b0;
    endtask

    ////////////////////
    // One branch from issue to completion

    task automatic run_branch(input logic [31:0] word);
        logic [31:0] pc;
        logic [31:0] actual;
        logic [31:0] presented;
        int          gap;
        logic        seen;
        if (timed_out) begin
            return;
        end
        pc  = $random(seed) & 32'hffff_fffc;
        gap = 1 + ($unsigned($random(seed)) % 3);
        @(negedge clk);
        new_request  = 1'b1;
        instruction  = word;
        rs1          = $random(seed);
        rs2          = (($random(seed) & 3) == 0) ? rs1 : $random(seed);
        dec_pc       = pc;
        dec_pc_valid = 1'b1;
        predict(word, pc, rs1, rs2);
        repeat (gap - 1) begin
            @(negedge clk);
            new_request  = 1'b0;
            dec_pc_valid = 1'b0;
            dec_pc       = $random(seed);
        end
        // Correct counter, correct with bit 0 set, or a wrong one
        actual = exp_taken ? exp_jump : exp_njump;
        case ($unsigned($random(seed)) % 3)
            0:       presented = actual;
            1:       presented = actual | 32'd1;
            default: presented = actual + 32'd4;
        endcase
        @(negedge clk);
        new_request  = 1'b0;
        dec_pc       = presented;
        dec_pc_valid = 1'b1;
        exp_flush    = (presented[31:1] != actual[31:1]);
        exp_ex       = 1'b1;
        seen         = 1'b0;
        for (int i = 0; (i < WAIT_LIMIT) && !seen; i++) begin
            @(posedge clk);
            seen = branch_ex;
        end
        if (!seen) begin
            timed_out = 1'b1;
            other_errors++;
            $display("Timed out at %0t waiting for branch_ex", $time);
            return;
        end
        @(negedge clk);
        dec_pc_valid = 1'b0;
        exp_ex       = 1'b0;
        // Pop before push, so call plus return replaces the top
        if (exp_return && (ras_model.size() > 0)) begin
            void'(ras_model.pop_back());
        end
        if (exp_call) begin
            ras_model.push_back(exp_njump);
            if (ras_model.size() > branch_pkg::RAS_DEPTH) begin
                void'(ras_model.pop_front());
            end
        end
        exp_top = (ras_model.size() == 0) ? 32'd0 : ras_model[$];
        if (exp_return) begin
            ret_ok  += branch_pkg::STAT_W'(!exp_flush);
            ret_bad += branch_pkg::STAT_W'(exp_flush);
        end else begin
            br_ok   += branch_pkg::STAT_W'(!exp_flush);
            br_bad  += branch_pkg::STAT_W'(exp_flush);
        end
    endtask

    ////////////////////
    // Checks

    ex_in_step: assert property (@(posedge clk) disable iff (rst) branch_ex == exp_ex)
        else value_error("branch_ex", $sampled(branch_ex), $sampled(exp_ex));

    always @(posedge clk) begin
        if (!rst) begin
            assert (flush == (exp_ex & exp_flush))
                else value_error("flush", flush, exp_ex & exp_flush);
            assert (ras_top == exp_top) else value_error("ras_top", ras_top, exp_top);
            assert (branches_ok == br_ok) else value_error("branches_ok", branches_ok, br_ok);
            assert (branches_bad == br_bad) else value_error("branches_bad", branches_bad, br_bad);
            assert (returns_ok == ret_ok) else value_error("returns_ok", returns_ok, ret_ok);
            assert (returns_bad == ret_bad) else value_error("returns_bad", returns_bad, ret_bad);
            if (exp_ex && branch_ex) begin
                assert (branch_taken == exp_taken)
                    else value_error("branch_taken", branch_taken, exp_taken);
                assert (jump_pc == exp_jump) else value_error("jump_pc", jump_pc, exp_jump);
                assert (njump_pc == exp_njump) else value_error("njump_pc", njump_pc, exp_njump);
            end
        end
    end

    initial begin
        seed         = 32'h948a_1351;
        rst          = 1'b1;
        new_request  = 1'b0;
        instruction  = '0;
        rs1          = '0;
        rs2          = '0;
        dec_pc       = '0;
        dec_pc_valid = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        // Return on the empty stack, five calls to overflow, then a replace
        run_branch(make_word(2, 5'd0, branch_pkg::LINK_RA));
        repeat (5) run_branch(make_word(1, branch_pkg::LINK_RA, 5'd0));
        run_branch(make_word(2, branch_pkg::LINK_T0, branch_pkg::LINK_RA));
        for (int n = 0; (n < NUM_BRANCHES) && !timed_out; n++) begin
            r = $random(seed);
            run_branch(make_word(int'(r[3:0] % 4'd3), link_or_any(r[15:8]),
                                 link_or_any(r[23:16])));
        end
        @(negedge clk);
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if ((value_errors == 0) && (other_errors == 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: build.f
src/branch_pkg.sv
src/branch_comparator.sv
src/branch_unit.sv
src/return_stack.sv
src/branch_stats.sv
src/branch_resolve_top.sv
verif/branch_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the branch resolution testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module branch_tb -f build.f -o sim_branch
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

output=$(./obj_dir/sim_branch)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "All tests passed!"; then
    exit 0
fi
exit 1
